// File: project.f
+incdir+source
source/dcache_pkg.sv
source/dcache_request_decode.sv
source/dcache_way_select.sv
source/dcache_data_ways.sv
source/dcache.sv
verif/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       ?= dcache_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
EXE       := V$(TOP)
PASS_MSG  := Test passed

.PHONY: help test clean

help:
	@echo "available targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(EXE)
	@out="$$(./$(BUILD_DIR)/$(EXE))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: verif/dcache_stim.txt
# op addr data size miss word  (hex addr, data and word, decimal size and miss)
# size is the store size for W (0 byte 1 half 2 word 3 illegal) and the wait cycles for F
N 00000 00000000 0 0 00000000
F 00404 11223344 2 1 11223344
R 00404 00000000 0 0 11223344
F 00808 A5A50F0F 0 0 A5A50F0F
R 00808 00000000 0 0 A5A50F0F
N 00000 00000000 0 0 00000000
W 00405 0000BB00 0 0 00000000
R 00404 00000000 0 0 1122BB44
W 00406 CAFE0000 1 0 00000000
R 00404 00000000 0 0 CAFEBB44
W 00404 FFFFFFFF 3 0 00000000
R 00404 00000000 0 0 CAFEBB44
W 00404 01020304 2 0 00000000
R 00404 00000000 0 0 01020304
N 00000 00000000 0 0 00000000
W 00C0C DEADBEEF 2 0 00000000
R 00C0C 00000000 0 0 DEADBEEF
W 01010 000000AA 0 0 00000000
F 01010 55667788 1 1 55667788
N 00000 00000000 0 0 00000000
F 02814 A0000001 1 1 A0000001
F 02C14 B0000002 2 1 B0000002
F 03014 C0000003 1 1 C0000003
F 03414 D0000004 3 1 D0000004
R 02814 00000000 0 0 A0000001
F 03814 E0000005 1 1 E0000005
R 02814 00000000 0 0 A0000001
R 03014 00000000 0 0 C0000003
R 03414 00000000 0 0 D0000004
R 03814 00000000 0 0 E0000005
F 02C14 B000000B 1 1 B000000B
N 00000 00000000 0 0 00000000
W 00404 0BADF00D 2 0 00000000
R 00404 00000000 0 0 0BADF00D
W 00407 77000000 0 0 00000000
R 00404 00000000 0 0 77ADF00D
N 00000 00000000 0 0 00000000

// File: verif/dcache_tb.sv
/*
  testbench of the 4-way data cache
  clock and reset, stimulus file reader, load, store, fill and idle drivers,
  value checks, watchdog and final verdict
*/
`timescale 1ns/1ps

module dcache_tb;

  localparam int CLK_PERIOD = 40;                     // ns
  localparam int DRIVE_DELAY = 2;                     // inputs change after the edge
  localparam int RESET_CYCLES = 4;
  localparam int CYCLES_PER_LINE = 20;                // watchdog budget
  localparam string STIM_FILE = "verif/dcache_stim.txt";

  // one line of the stimulus file
  typedef struct packed {
    logic [7:0] op;                                   // R, W, F or N
    dcache_pkg::addr_t addr;
    dcache_pkg::word_t data;                          // store data or fill word
    logic [7:0] size;                                 // store size, wait cycles for F
    logic miss;                                       // cache_miss in the response cycle
    dcache_pkg::word_t word;                          // expected load word
  } stim_op_t;

  logic CLK;
  logic rst_n;
  logic read_en;
  logic write_en;
  logic fetch;
  dcache_pkg::addr_t read_addr;
  dcache_pkg::addr_t write_addr;
  dcache_pkg::word_t write_data;
  dcache_pkg::size_t store_size;
  logic cache_miss;
  logic rdata_valid;
  dcache_pkg::word_t rdata;

  stim_op_t ops [$];
  int line_count;
  int error_count;
  logic stim_loaded;                                  // starts the watchdog

  dcache dcache_i (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .read_en     (read_en),
    .write_en    (write_en),
    .fetch       (fetch),
    .read_addr   (read_addr),
    .write_addr  (write_addr),
    .write_data  (write_data),
    .store_size  (store_size),
    .cache_miss  (cache_miss),
    .rdata_valid (rdata_valid),
    .rdata       (rdata)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at time %0d ns: %s is %h, expected %h",
               $time, name, actual, expected);
      error_count++;
    end
  endtask

  task automatic read_stim_file();
    int fd;
    int n;
    string line;
    logic [7:0] op_c;
    dcache_pkg::addr_t addr;
    dcache_pkg::word_t data;
    logic [7:0] size;
    logic miss;
    dcache_pkg::word_t word;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("could not open the stimulus file %s", STIM_FILE);
      error_count++;
      return;
    end
    while ($fgets(line, fd) > 0) begin
      line_count++;
      if (line.len() > 1 && line.getc(0) != "#") begin  // skip comments and blank lines
        n = $sscanf(line, "%c %h %h %d %d %h", op_c, addr, data, size, miss, word);
        if (n == 6) begin
          ops.push_back('{op: op_c, addr: addr, data: data, size: size,
                          miss: miss, word: word});
        end else begin
          $display("stimulus line %0d could not be read: %s", line_count, line);
          error_count++;
        end
      end
    end
    $fclose(fd);
  endtask

  // request edge, then checks in the lookup cycle before the next drive
  task automatic issue_load(input stim_op_t entry);
    read_en = 1'b1;
    read_addr = entry.addr;
    @(posedge CLK);
    #1;
    check_value("cache_miss", 32'(cache_miss), 32'(entry.miss));
    check_value("rdata_valid", 32'(rdata_valid), 32'(!entry.miss));
    if (!entry.miss) check_value("rdata", rdata, entry.word);
    #(DRIVE_DELAY - 1);
    read_en = 1'b0;                                   // next request may follow at once
  endtask

  task automatic issue_store(input stim_op_t entry);
    write_en = 1'b1;
    write_addr = entry.addr;
    write_data = entry.data;                          // lane aligned
    store_size = entry.size[1:0];
    @(posedge CLK);
    #1;                                               // store commit cycle
    check_value("cache_miss", 32'(cache_miss), 32'(entry.miss));
    check_value("rdata_valid", 32'(rdata_valid), 32'd0);
    #(DRIVE_DELAY - 1);
    write_en = 1'b0;
  endtask

  // fetch acts in the cycle it is driven, so these cycles are sampled at negedge
  task automatic load_with_fill(input stim_op_t entry);
    int k;
    read_en = 1'b1;
    read_addr = entry.addr;
    @(posedge CLK);
    #DRIVE_DELAY;
    read_en = 1'b0;
    for (k = 0; k < entry.size; k++) begin
      @(negedge CLK);
      check_value("cache_miss", 32'(cache_miss), (k == 0) ? 32'(entry.miss) : 32'd1);
      check_value("rdata_valid", 32'(rdata_valid), 32'd0);
      @(posedge CLK);
      #DRIVE_DELAY;
    end
    fetch = 1'b1;                                     // memory answers
    write_data = entry.data;
    @(negedge CLK);
    check_value("cache_miss", 32'(cache_miss), (entry.size == 0) ? 32'(entry.miss) : 32'd0);
    check_value("rdata_valid", 32'(rdata_valid), 32'd1);
    check_value("rdata", rdata, entry.word);
    @(posedge CLK);
    #DRIVE_DELAY;
    fetch = 1'b0;
  endtask

  task automatic idle_cycle(input stim_op_t entry);
    @(posedge CLK);
    #1;
    check_value("cache_miss", 32'(cache_miss), 32'(entry.miss));
    check_value("rdata_valid", 32'(rdata_valid), 32'd0);
    #(DRIVE_DELAY - 1);
  endtask

  initial begin
    rst_n = 1'b0;
    read_en = 1'b0;
    write_en = 1'b0;
    fetch = 1'b0;
    read_addr = '0;
    write_addr = '0;
    write_data = '0;
    store_size = '0;
    line_count = 0;
    error_count = 0;
    stim_loaded = 1'b0;
    read_stim_file();
    stim_loaded = 1'b1;
    if (ops.size() == 0) begin
      $display("no operations in the stimulus file, nothing was run");
      error_count++;
    end
    repeat (RESET_CYCLES) @(posedge CLK);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    check_value("cache_miss", 32'(cache_miss), 32'd0);  // quiet after reset
    check_value("rdata_valid", 32'(rdata_valid), 32'd0);
    check_value("commit.en", 32'(dcache_i.commit.en), 32'd0);
    foreach (ops[i]) begin
      case (ops[i].op)
        "R": issue_load(ops[i]);
        "W": issue_store(ops[i]);
        "F": load_with_fill(ops[i]);
        "N": idle_cycle(ops[i]);
        default: begin
          $display("unknown operation code %c in the stimulus file", ops[i].op);
          error_count++;
        end
      endcase
    end
    $display("%0d operations run, %0d errors", ops.size(), error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // budget grows with the stimulus length
  initial begin
    wait (stim_loaded);
    #((line_count + 1) * CYCLES_PER_LINE * CLK_PERIOD);
    $display("timeout, the operations did not finish in time");
    $display("Test failed");
    $finish;
  end

endmodule

// File: source/dcache.sv
/*
  4-way set-associative data cache, top level
  request decode, way select and data ways
*/
`timescale 1ns/1ps

module dcache (
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              read_en,
  input  logic              write_en,
  input  logic              fetch,
  input  dcache_pkg::addr_t read_addr,
  input  dcache_pkg::addr_t write_addr,
  input  dcache_pkg::word_t write_data,
  input  dcache_pkg::size_t store_size,
  output logic              cache_miss,
  output logic              rdata_valid,
  output dcache_pkg::word_t rdata
);

  dcache_pkg::set_t rd_set;                 // array read index
  dcache_pkg::lookup_t lookup;              // set and tag under compare
  dcache_pkg::commit_t commit;              // update of all state
  dcache_pkg::way_info_t way_info;

  dcache_request_decode decode_i (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .read_en     (read_en),
    .write_en    (write_en),
    .fetch       (fetch),
    .read_addr   (read_addr),
    .write_addr  (write_addr),
    .write_data  (write_data),
    .store_size  (store_size),
    .way_info    (way_info),
    .rd_set      (rd_set),
    .lookup      (lookup),
    .commit      (commit),
    .cache_miss  (cache_miss),
    .rdata_valid (rdata_valid)
  );

  dcache_way_select way_select_i (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .rd_set   (rd_set),
    .lookup   (lookup),
    .commit   (commit),
    .way_info (way_info)
  );

  dcache_data_ways data_ways_i (
    .CLK      (CLK),
    .rd_set   (rd_set),
    .commit   (commit),
    .way_info (way_info),
    .rdata    (rdata)
  );

endmodule

// File: source/dcache_data_ways.sv
/*
  data storage of the data cache
  four word arrays with byte writes and the load result mux
*/
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_data_ways (
  input  logic                  CLK,
  input  dcache_pkg::set_t      rd_set,
  input  dcache_pkg::commit_t   commit,
  input  dcache_pkg::way_info_t way_info,
  output dcache_pkg::word_t     rdata
);

  localparam int BYTES = `DC_WORD_W / 8;

  dcache_pkg::word_t way_word [`DC_WAYS];               // words read at the last edge

  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
    dcache_pkg::word_t mem [`DC_SETS];
    dcache_pkg::word_t rd_q;
    logic wr;
    logic same_set;

    assign wr = commit.en && commit.way == dcache_pkg::way_t'(w);
    assign same_set = commit.set == rd_set;

    always_ff @(posedge CLK) begin
      for (int b = 0; b < BYTES; b++) begin
        if (wr && commit.byte_en[b]) begin
          mem[commit.set][8*b +: 8] <= commit.wdata[8*b +: 8];
        end
        // write-first per byte, untouched bytes from the array
        if (wr && commit.byte_en[b] && same_set) begin
          rd_q[8*b +: 8] <= commit.wdata[8*b +: 8];
        end else begin
          rd_q[8*b +: 8] <= mem[rd_set][8*b +: 8];
        end
      end
    end

    assign way_word[w] = rd_q;
  end

  // fill bypasses the arrays, else the hit way
  assign rdata = (commit.en && commit.fill) ? commit.wdata : way_word[way_info.hit_way];

endmodule

// File: source/dcache_way_select.sv
/*
  way selection of the data cache
  tag arrays per way, valid bits and LRU ages in flops,
  hit detection, victim choice and age update on commit
*/
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_way_select (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  dcache_pkg::set_t      rd_set,
  input  dcache_pkg::lookup_t   lookup,
  input  dcache_pkg::commit_t   commit,
  output dcache_pkg::way_info_t way_info
);

  localparam dcache_pkg::age_t AGE_OLDEST = dcache_pkg::age_t'(`DC_WAYS - 1);

  logic [`DC_WAYS-1:0] valid_q [`DC_SETS];
  dcache_pkg::age_t age_q [`DC_SETS][`DC_WAYS];
  dcache_pkg::tag_t tag_rd [`DC_WAYS];                  // tags read at the last edge
  dcache_pkg::age_t old_age;                            // age of committed way before update
  logic [`DC_WAYS-1:0] cur_valid;
  dcache_pkg::age_t cur_age [`DC_WAYS];
  logic hit;
  dcache_pkg::way_t hit_way;
  dcache_pkg::way_t victim_way;

  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_tag
    dcache_pkg::tag_t tag_mem [`DC_SETS];
    dcache_pkg::tag_t rd_q;
    logic wr;

    assign wr = commit.en && commit.way == dcache_pkg::way_t'(w);

    always_ff @(posedge CLK) begin
      if (wr) tag_mem[commit.set] <= commit.tag;
      if (wr && commit.set == rd_set) rd_q <= commit.tag;   // write-first
      else rd_q <= tag_mem[rd_set];
    end

    assign tag_rd[w] = rd_q;
    assign cur_age[w] = age_q[lookup.set][w];
  end

  assign cur_valid = valid_q[lookup.set];               // flops, always current
  assign old_age = age_q[commit.set][commit.way];

  always_comb begin
    hit = 1'b0;
    hit_way = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (cur_valid[w] && tag_rd[w] == lookup.tag) begin
        hit = 1'b1;
        hit_way = dcache_pkg::way_t'(w);
      end
    end
  end

  // oldest way first, then lowest invalid way overrides
  always_comb begin
    victim_way = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (cur_age[w] == AGE_OLDEST) victim_way = dcache_pkg::way_t'(w);
    end
    for (int w = `DC_WAYS - 1; w >= 0; w--) begin
      if (!cur_valid[w]) victim_way = dcache_pkg::way_t'(w);
    end
  end

  assign way_info = '{hit: hit, hit_way: hit_way, victim_way: victim_way};

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int s = 0; s < `DC_SETS; s++) begin
        valid_q[s] <= '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
          age_q[s][w] <= dcache_pkg::age_t'(w);         // ways 0..3 get ages 0..3
        end
      end
    end else if (commit.en) begin
      valid_q[commit.set][commit.way] <= 1'b1;
      for (int w = 0; w < `DC_WAYS; w++) begin
        if (dcache_pkg::way_t'(w) == commit.way) begin
          age_q[commit.set][w] <= '0;                   // now most recent
        end else if (age_q[commit.set][w] < old_age) begin
          age_q[commit.set][w] <= age_q[commit.set][w] + 1'b1;
        end
      end
    end
  end

endmodule

// File: source/dcache_request_decode.sv
/*
  request control of the data cache
  state machine, latched request, address split, byte enables
  and the commit decision for load hits, stores and fills
*/
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_request_decode (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  read_en,
  input  logic                  write_en,
  input  logic                  fetch,
  input  dcache_pkg::addr_t     read_addr,
  input  dcache_pkg::addr_t     write_addr,
  input  dcache_pkg::word_t     write_data,
  input  dcache_pkg::size_t     store_size,
  input  dcache_pkg::way_info_t way_info,
  output dcache_pkg::set_t      rd_set,
  output dcache_pkg::lookup_t   lookup,
  output dcache_pkg::commit_t   commit,
  output logic                  cache_miss,
  output logic                  rdata_valid
);

  localparam int SET_LSB = 2;                                   // word aligned lines
  localparam int TAG_LSB = `DC_ADDR_W - `DC_TAG_W;
  localparam dcache_pkg::size_t SZ_BYTE = 2'd0;
  localparam dcache_pkg::size_t SZ_HALF = 2'd1;
  localparam dcache_pkg::size_t SZ_WORD = 2'd2;
  localparam dcache_pkg::size_t SZ_ILLEGAL = 2'd3;

  dcache_pkg::ctrl_state_e state_q, state_d;
  dcache_pkg::addr_t addr_q;                                    // latched request address
  dcache_pkg::size_t size_q;
  dcache_pkg::word_t data_q;                                    // latched store data
  dcache_pkg::addr_t in_addr;
  dcache_pkg::byte_en_t store_be;
  logic accept;                                                 // request sampled this edge
  logic fill_now;

  assign in_addr = read_en ? read_addr : write_addr;            // load wins over store
  assign lookup = '{set: addr_q[SET_LSB +: `DC_SET_W], tag: addr_q[TAG_LSB +: `DC_TAG_W]};
  assign rd_set = accept ? in_addr[SET_LSB +: `DC_SET_W] : lookup.set;  // miss rereads own set

  always_comb begin
    case (size_q)
      SZ_BYTE:    store_be = dcache_pkg::byte_en_t'(1) << addr_q[1:0];
      SZ_HALF:    store_be = addr_q[1] ? 4'b1100 : 4'b0011;     // aligned halves only
      SZ_WORD:    store_be = '1;
      SZ_ILLEGAL: store_be = '0;                                // no effect
      default:    store_be = '0;
    endcase
  end

  always_comb begin
    accept = 1'b0;
    fill_now = 1'b0;
    cache_miss = 1'b0;
    rdata_valid = 1'b0;
    state_d = state_q;
    commit.en = 1'b0;
    commit.way = way_info.hit_way;
    commit.set = lookup.set;
    commit.tag = lookup.tag;                                    // fill tag from latched load
    commit.fill = 1'b0;
    commit.byte_en = '0;                                        // load hit touches ages only
    commit.wdata = data_q;
    case (state_q)
      dcache_pkg::IDLE: accept = 1'b1;
      dcache_pkg::LOOKUP: begin
        if (way_info.hit) begin
          rdata_valid = 1'b1;
          commit.en = 1'b1;                                     // recency update
          accept = 1'b1;
        end else if (fetch) begin
          fill_now = 1'b1;                                      // memory answered at once
        end else begin
          cache_miss = 1'b1;
          state_d = dcache_pkg::MISS;
        end
      end
      dcache_pkg::STORE: begin
        accept = 1'b1;
        if (size_q != SZ_ILLEGAL && (way_info.hit || size_q == SZ_WORD)) begin
          commit.en = 1'b1;
          commit.way = way_info.hit ? way_info.hit_way : way_info.victim_way;
          commit.byte_en = store_be;
        end                                                     // partial store miss dropped
      end
      dcache_pkg::MISS: begin
        if (fetch) fill_now = 1'b1;
        else cache_miss = 1'b1;                                 // held until fetch
      end
      default: state_d = dcache_pkg::IDLE;
    endcase
    if (fill_now) begin
      rdata_valid = 1'b1;
      commit.en = 1'b1;
      commit.fill = 1'b1;
      commit.way = way_info.victim_way;
      commit.byte_en = '1;
      commit.wdata = write_data;                                // fill word from memory side
      state_d = dcache_pkg::IDLE;
    end
    if (accept) begin
      if (read_en) state_d = dcache_pkg::LOOKUP;
      else if (write_en) state_d = dcache_pkg::STORE;
      else state_d = dcache_pkg::IDLE;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) state_q <= dcache_pkg::IDLE;
    else state_q <= state_d;
  end

  always_ff @(posedge CLK) begin
    if (accept && read_en) begin
      addr_q <= read_addr;
    end else if (accept && write_en) begin
      addr_q <= write_addr;
      size_q <= store_size;
      data_q <= write_data;                                     // lane aligned store data
    end
  end

endmodule

// File: source/dcache_pkg.sv
/*
  shared types of the data cache
  vector typedefs, request state enum, lookup, commit and way info structs
*/
`include "dcache_defs.svh"

package dcache_pkg;

  typedef logic [`DC_ADDR_W-1:0] addr_t;           // byte address
  typedef logic [`DC_SET_W-1:0] set_t;             // addr[9:2]
  typedef logic [`DC_TAG_W-1:0] tag_t;             // addr[19:10]
  typedef logic [$clog2(`DC_WAYS)-1:0] way_t;
  typedef logic [$clog2(`DC_WAYS)-1:0] age_t;      // 0 = most recent
  typedef logic [`DC_WORD_W-1:0] word_t;
  typedef logic [`DC_WORD_W/8-1:0] byte_en_t;
  typedef logic [1:0] size_t;                      // 0 byte, 1 half, 2 word, 3 illegal

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,                                        // load compare cycle
    STORE,                                         // store commit cycle
    MISS                                           // waiting for fetch
  } ctrl_state_e;

  typedef struct packed {
    set_t set;
    tag_t tag;
  } lookup_t;

  // one update of tag, valid, age and data state
  typedef struct packed {
    logic en;
    way_t way;
    set_t set;
    tag_t tag;
    logic fill;                                    // word comes from memory side
    byte_en_t byte_en;                             // all zero on load hit
    word_t wdata;
  } commit_t;

  typedef struct packed {
    logic hit;
    way_t hit_way;
    way_t victim_way;                              // first invalid, else age 3
  } way_info_t;

endpackage

// File: source/dcache_defs.svh
/*
  geometry macros of the 4-way data cache
  address split, set count, tag and data widths
*/
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// byte address, 1 MB reachable
`define DC_ADDR_W 20

// one 32-bit word per line, set index from addr[9:2]
`define DC_SET_W 8
`define DC_SETS 256

// tag from addr[19:10]
`define DC_TAG_W 10

`define DC_WAYS 4
`define DC_WORD_W 32

`endif
